// ==== dv/icache_testdata.txt ====
// Columns: fetch byte address (hex), expected miss flag (1 = miss, 0 = hit)
// Set is addr[7:4], tag addr[31:8]; each set fills ways 0, 1, 2, 3, then wraps
00001000 1
00001004 0
0000100C 0
00001008 0
00002000 1
00003000 1
00004000 1
00005004 1
00001000 1
00002008 1
0000500C 0
00004004 0
00000010 1
0000001C 0
00000ABC 1
00000AB0 0
12345670 1
12345678 0
00001000 0
00001014 1

// ==== sources.f ====
+incdir+rtl
rtl/icache_pkg.sv
rtl/cache_array_if.sv
rtl/icache_ctrl.sv
rtl/icache_tag_array.sv
rtl/icache_data_array.sv
rtl/icache_top.sv
dv/icache_checker.sv
dv/tb_icache.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Compile and run the icache testbench with Verilator
set -o pipefail
cd "$(dirname "$0")" || exit 1
LOG=sim.log
verilator --binary --timing --assert --top-module tb_icache -f sources.f -o sim_icache \
    && ./obj_dir/sim_icache 2>&1 | tee "$LOG" \
    || { echo "Build or simulation run did not complete"; exit 1; }
grep -q "Test failures found" "$LOG" && { echo "Simulation reported errors"; exit 1; }
echo "Simulation clean"
exit 0

// ==== dv/tb_icache.sv ====
module tb_icache;
    timeunit 1ns;
    timeprecision 1ps;
    import icache_pkg::*;

    localparam logic [31:0] mem_pattern = 32'hA5C3_0000;
    localparam int          cycle_ns    = 4;

    logic         clk_i;
    logic         rst_i;
    logic         p_strobe;
    logic [31:0]  p_addr;
    logic         p_ready;
    logic [31:0]  p_data;
    logic         m_strobe;
    logic [31:0]  m_addr;
    cache_line_u  m_data;
    logic         m_ready;
    logic         exp_miss;

    // Fetch list from the data file
    logic [31:0]  fetch_addr_q [$];
    logic         fetch_miss_q [$];
    logic         loaded = 1'b0;
    int           tb_errors = 0;
    int           checker_errors;
    int           fetches_checked;

    icache_top UUT (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .p_strobe_i (p_strobe),
        .p_addr_i   (p_addr),
        .p_ready_o  (p_ready),
        .p_data_o   (p_data),
        .m_strobe_o (m_strobe),
        .m_addr_o   (m_addr),
        .m_data_i   (m_data),
        .m_ready_i  (m_ready)
    );

    icache_checker #(.mem_pattern(mem_pattern)) u_checker (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .p_strobe_i  (p_strobe),
        .p_addr_i    (p_addr),
        .exp_miss_i  (exp_miss),
        .p_ready_i   (p_ready),
        .p_data_i    (p_data),
        .m_strobe_i  (m_strobe),
        .m_addr_i    (m_addr),
        .m_ready_i   (m_ready),
        .error_cnt_o (checker_errors),
        .fetch_cnt_o (fetches_checked)
    );

    initial
    begin
        clk_i = 1'b0;
        forever #(cycle_ns / 2) clk_i = ~clk_i;
    end

    // ========================================
    // Stimulus
    // ========================================

    // Lines starting with / are comments, others hold address and miss flag
    task automatic load_fetches();
        int           fd;
        int           code;
        int           miss;
        string        line;
        logic [31:0]  addr;
        fd = $fopen("dv/icache_testdata.txt", "r");
        if (fd == 0)
        begin
            $display("Cannot open the fetch list dv/icache_testdata.txt");
            tb_errors++;
            return;
        end
        while (!$feof(fd))
        begin
            code = $fgets(line, fd);
            if ((code > 0) && (line.getc(0) != "/") && ($sscanf(line, "%h %d", addr, miss) == 2))
            begin
                fetch_addr_q.push_back(addr);
                fetch_miss_q.push_back(miss != 0);
            end
        end
        $fclose(fd);
        if (fetch_addr_q.size() == 0)
        begin
            $display("The fetch list holds no entries");
            tb_errors++;
        end
    endtask

    task automatic run_fetch(input logic [31:0] addr, input logic miss);
        @(negedge clk_i);
        p_addr   = addr;
        exp_miss = miss;
        p_strobe = 1'b1;
        @(negedge clk_i);
        p_strobe = 1'b0;
        // Ready is sampled at the edge that closes its cycle
        do
            @(posedge clk_i);
        while (p_ready !== 1'b1);
        // A miss passes through the finish state before idle
        @(negedge clk_i);
    endtask

    task automatic finish_run();
        if (fetches_checked != fetch_addr_q.size())
        begin
            $display("Only %0d of %0d fetches returned data", fetches_checked,
                     fetch_addr_q.size());
            tb_errors++;
        end
        $display("Errors: %0d checker, %0d testbench, %0d of %0d fetches checked",
                 checker_errors, tb_errors, fetches_checked, fetch_addr_q.size());
        if (checker_errors + tb_errors == 0)
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    endtask

    initial
    begin
        rst_i    = 1'b1;
        p_strobe = 1'b0;
        p_addr   = '0;
        exp_miss = 1'b0;
        load_fetches();
        loaded = 1'b1;
        repeat (3) @(negedge clk_i);
        rst_i = 1'b0;
        // Valid bits are still being cleared
        repeat (20) @(negedge clk_i);
        foreach (fetch_addr_q[i])
            run_fetch(fetch_addr_q[i], fetch_miss_q[i]);
        repeat (3) @(negedge clk_i);
        finish_run();
    end

    // ========================================
    // Memory model and watchdog
    // ========================================

    // One line per request, returned after 2 to 9 cycles
    initial
    begin
        logic [31:0]  line_addr;
        int unsigned  delay;
        void'($urandom(21651));
        m_ready = 1'b0;
        m_data  = '0;
        forever
        begin
            @(negedge clk_i);
            if (m_strobe === 1'b1)
            begin
                line_addr = m_addr;
                delay     = 2 + ($urandom % 8);
                repeat (delay) @(negedge clk_i);
                for (int w = 0; w < 4; w++)
                    m_data.words[w] = (line_addr + 32'(4 * w)) ^ mem_pattern;
                m_ready = 1'b1;
                @(negedge clk_i);
                m_ready = 1'b0;
            end
        end
    end

    // Budget of 20 cycles per fetch plus margin for reset and init
    initial
    begin
        wait (loaded);
        #(fetch_addr_q.size() * 20 * cycle_ns + 200);
        $display("Watchdog expired before the fetch sequence completed");
        $display("Test failures found");
        $finish;
    end

endmodule

// ==== dv/icache_checker.sv ====
module icache_checker #(
    parameter logic [31:0] mem_pattern = 32'hA5C3_0000
) (
    input  logic         clk_i,
    input  logic         rst_i,
    // Fetch port as seen by the DUT
    input  logic         p_strobe_i,
    input  logic [31:0]  p_addr_i,
    input  logic         exp_miss_i,
    input  logic         p_ready_i,
    input  logic [31:0]  p_data_i,
    // Memory port
    input  logic         m_strobe_i,
    input  logic [31:0]  m_addr_i,
    input  logic         m_ready_i,
    output int           error_cnt_o,
    output int           fetch_cnt_o
);
    timeunit 1ns;
    timeprecision 1ps;

    // Fetch in flight from strobe to ready
    logic         busy = 1'b0;
    logic         data_due = 1'b0;
    logic         cur_miss;
    logic [31:0]  cur_addr;
    logic [31:0]  exp_data;
    logic [31:0]  line_addr;
    int           cycle = 0;
    int           strobe_cycle = 0;
    int           mreq_cnt = 0;
    int           rst_cycles = 0;
    int           errors = 0;
    int           fetches = 0;

    assign error_cnt_o = errors;
    assign fetch_cnt_o = fetches;

    task automatic report_mismatch(input string sig, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("FAILED %s at fetch %h: got %h, expected %h", sig, cur_addr, got, exp);
        errors++;
    endtask

    task automatic report_problem(input string what);
        $display("Error at cycle %0d: %s", cycle, what);
        errors++;
    endtask

    // ========================================
    // Sampled at the rising edge
    // ========================================

    always @(posedge clk_i)
    begin
        cycle++;
        if (rst_i)
        begin
            busy     = 1'b0;
            data_due = 1'b0;
            rst_cycles++;
            // First edge still shows the power-up values
            if ((rst_cycles > 1) && (p_ready_i || m_strobe_i))
                report_problem("p_ready_o or m_strobe_o high during reset");
        end
        else
        begin
            // Word arrives one cycle after p_ready_o
            if (data_due)
            begin
                data_due = 1'b0;
                fetches++;
                if (p_data_i !== exp_data)
                    report_mismatch("p_data_o", p_data_i, exp_data);
            end

            if (p_strobe_i)
            begin
                busy         = 1'b1;
                cur_addr     = p_addr_i;
                cur_miss     = exp_miss_i;
                strobe_cycle = cycle;
                mreq_cnt     = 0;
                line_addr    = {p_addr_i[31:4], 4'h0};
            end

            // Line request must be line aligned and held until memory answers
            if (m_strobe_i)
            begin
                if (!busy)
                    report_problem("m_strobe_o with no fetch in progress");
                mreq_cnt++;
                if (m_addr_i !== line_addr)
                    report_mismatch("m_addr_o", m_addr_i, line_addr);
            end
            if (m_ready_i && busy && (m_addr_i !== line_addr))
                report_mismatch("m_addr_o", m_addr_i, line_addr);

            if (p_ready_i)
            begin
                if (!busy)
                    report_problem("p_ready_o with no fetch in progress");
                else if (cur_miss && (mreq_cnt != 1))
                    report_problem($sformatf("miss at %h made %0d line requests, expected 1",
                                             cur_addr, mreq_cnt));
                else if (!cur_miss && (mreq_cnt != 0))
                    report_problem($sformatf("hit at %h made a line request", cur_addr));
                else if (!cur_miss && (cycle - strobe_cycle != 1))
                    report_problem($sformatf("hit at %h answered after %0d cycles, expected 1",
                                             cur_addr, cycle - strobe_cycle));
                // Memory word at byte address A holds A xor the pattern
                exp_data = {cur_addr[31:2], 2'b00} ^ mem_pattern;
                data_due = 1'b1;
                busy     = 1'b0;
            end
        end
    end

endmodule

// ==== rtl/icache_top.sv ====
`include "icache_consts.svh"

module icache_top (
    input  logic                      clk_i,
    input  logic                      rst_i,

    // Fetch port
    input  logic                      p_strobe_i,
    input  logic [`ICACHE_XLEN-1:0]   p_addr_i,
    output logic                      p_ready_o,
    output logic [`ICACHE_XLEN-1:0]   p_data_o,

    // Memory port, one line per request
    output logic                      m_strobe_o,
    output logic [`ICACHE_XLEN-1:0]   m_addr_o,
    input  icache_pkg::cache_line_u   m_data_i,
    input  logic                      m_ready_i
);

    // Controller to tag and data arrays
    cache_array_if arr_if ();

    icache_ctrl u_ctrl (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .p_strobe_i (p_strobe_i),
        .p_addr_i   (p_addr_i),
        .m_ready_i  (m_ready_i),
        .p_ready_o  (p_ready_o),
        .m_strobe_o (m_strobe_o),
        .m_addr_o   (m_addr_o),
        .arr        (arr_if.ctrl)
    );

    icache_tag_array u_tags (
        .clk_i (clk_i),
        .rst_i (rst_i),
        .arr   (arr_if.tags)
    );

    // Line data, also the source of p_data_o
    icache_data_array u_data (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .p_addr_i  (p_addr_i),
        .m_data_i  (m_data_i),
        .m_ready_i (m_ready_i),
        .p_data_o  (p_data_o),
        .arr       (arr_if.data)
    );

endmodule

// ==== rtl/icache_data_array.sv ====
`include "icache_consts.svh"

module icache_data_array (
    input  logic                      clk_i,
    input  logic                      rst_i,
    input  logic [`ICACHE_XLEN-1:0]   p_addr_i,
    input  icache_pkg::cache_line_u   m_data_i,
    input  logic                      m_ready_i,
    output logic [`ICACHE_XLEN-1:0]   p_data_o,
    cache_array_if.data               arr
);
    import icache_pkg::*;

    set_index_t                       rd_idx;
    logic [`ICACHE_OFFSET_BITS-1:0]   offset;
    cache_line_u                      way_line [`ICACHE_WAYS];
    logic [`ICACHE_XLEN-1:0]          sel_word;

    // Read from the fetch address so the line is out the cycle after the strobe
    assign rd_idx = p_addr_i[`ICACHE_INDEX_LSB +: `ICACHE_INDEX_BITS];
    assign offset = p_addr_i[`ICACHE_OFFSET_LSB +: `ICACHE_OFFSET_BITS];

    // ========================================
    // Line storage
    // ========================================

    for (genvar w = 0; w < `ICACHE_WAYS; w++)
    begin : g_way
        logic [`ICACHE_LINE_BITS-1:0]  line_mem [`ICACHE_SETS];
        cache_line_u                   line_q;

        always_ff @(posedge clk_i)
        begin
            if (arr.fill_we[w])
                line_mem[arr.set_idx] <= m_data_i.flat;
        end

        // Synchronous read, write-first so a fresh refill reads back at once
        always_ff @(posedge clk_i)
        begin
            if (arr.fill_we[w] && (arr.set_idx == rd_idx))
                line_q <= m_data_i;
            else
                line_q.flat <= line_mem[rd_idx];
        end

        assign way_line[w] = line_q;
    end

    // ========================================
    // Word select and output register
    // ========================================

    // Miss takes the word straight from memory
    assign sel_word = m_ready_i ? m_data_i.words[offset]
                    : way_line[arr.hit_way].words[offset];

    always_ff @(posedge clk_i)
    begin
        if (rst_i)
            p_data_o <= '0;
        else
            p_data_o <= sel_word;
    end

endmodule

// ==== rtl/icache_tag_array.sv ====
`include "icache_consts.svh"

module icache_tag_array (
    input  logic          clk_i,
    input  logic          rst_i,
    cache_array_if.tags   arr
);
    import icache_pkg::*;

    logic [`ICACHE_WAYS-1:0]  way_hit;
    way_sel_t                 hit_enc;
    way_sel_t                 fifo_cnt_q [`ICACHE_SETS];

    // ========================================
    // Tag and valid storage
    // ========================================

    for (genvar w = 0; w < `ICACHE_WAYS; w++)
    begin : g_way
        tag_t  tag_mem   [`ICACHE_SETS];
        logic  valid_mem [`ICACHE_SETS];

        // Tag only changes on refill of this way
        always_ff @(posedge clk_i)
        begin
            if (arr.fill_we[w])
                tag_mem[arr.set_idx] <= arr.lookup_tag;
        end

        // Cleared during init, set on refill
        always_ff @(posedge clk_i)
        begin
            if (arr.valid_we[w])
                valid_mem[arr.set_idx] <= arr.valid_wdata;
        end

        // Asynchronous read and compare
        assign way_hit[w] = valid_mem[arr.set_idx]
                          && (tag_mem[arr.set_idx] == arr.lookup_tag);
    end

    // ========================================
    // Hit detection and victim select
    // ========================================

    // Way number of the matching way
    always_comb
    begin
        hit_enc = '0;
        for (int w = 0; w < `ICACHE_WAYS; w++)
        begin
            if (way_hit[w])
                hit_enc = way_sel_t'(w);
        end
    end

    // FIFO pointer per set, next way to be replaced
    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            for (int s = 0; s < `ICACHE_SETS; s++)
                fifo_cnt_q[s] <= '0;
        end
        else if (arr.fifo_advance)
        begin
            fifo_cnt_q[arr.set_idx] <= fifo_cnt_q[arr.set_idx] + 1'b1;
        end
    end

    assign arr.hit     = |way_hit;
    // Miss hands the victim to the controller on the same lines
    assign arr.hit_way = arr.hit ? hit_enc : fifo_cnt_q[arr.set_idx];

    // A line is only filled after a miss, so a tag lives in one way at most
    // Skipped while the valid bits are being cleared
    a_onehot_hit: assert property (@(posedge clk_i) disable iff (rst_i)
        !((arr.valid_we != '0) && !arr.valid_wdata) |-> $onehot0(way_hit));

endmodule

// ==== rtl/icache_ctrl.sv ====
`include "icache_consts.svh"

module icache_ctrl (
    input  logic                     clk_i,
    input  logic                     rst_i,
    input  logic                     p_strobe_i,
    input  logic [`ICACHE_XLEN-1:0]  p_addr_i,
    input  logic                     m_ready_i,
    output logic                     p_ready_o,
    output logic                     m_strobe_o,
    output logic [`ICACHE_XLEN-1:0]  m_addr_o,
    cache_array_if.ctrl              arr
);
    import icache_pkg::*;

    typedef enum logic [2:0] {
        ST_INIT,
        ST_IDLE,
        ST_COMPARE,
        ST_FETCH,
        ST_FINISH
    } state_t;

    state_t                    state_q;
    state_t                    state_d;
    set_index_t                clr_cnt_q;
    logic [`ICACHE_XLEN-1:0]   addr_q;
    logic                      refill;
    logic [`ICACHE_WAYS-1:0]   fill_we;

    // ========================================
    // FSM
    // ========================================

    always_ff @(posedge clk_i)
    begin
        if (rst_i)
            state_q <= ST_INIT;
        else
            state_q <= state_d;
    end

    always_comb
    begin
        state_d = state_q;
        case (state_q)
            // One set cleared per cycle
            ST_INIT:
                if (clr_cnt_q == set_index_t'(`ICACHE_SETS - 1))
                    state_d = ST_IDLE;
            ST_IDLE:
                if (p_strobe_i)
                    state_d = ST_COMPARE;
            ST_COMPARE:
                state_d = arr.hit ? ST_IDLE : ST_FETCH;
            // Wait for the line from memory
            ST_FETCH:
                if (m_ready_i)
                    state_d = ST_FINISH;
            ST_FINISH:
                state_d = ST_IDLE;
            default:
                state_d = ST_INIT;
        endcase
    end

    // Valid-clear counter, walks every set once after reset
    always_ff @(posedge clk_i)
    begin
        if (rst_i)
            clr_cnt_q <= '0;
        else if (state_q == ST_INIT)
            clr_cnt_q <= clr_cnt_q + 1'b1;
    end

    // Fetch address, captured at the strobe
    always_ff @(posedge clk_i)
    begin
        if ((state_q == ST_IDLE) && p_strobe_i)
            addr_q <= p_addr_i;
    end

    // ========================================
    // Array control
    // ========================================

    assign refill = (state_q == ST_FETCH) && m_ready_i;

    // Victim way to one-hot, hit_way holds the victim while missing
    always_comb
    begin
        fill_we = '0;
        if (refill)
            fill_we[arr.hit_way] = 1'b1;
    end

    assign arr.set_idx      = (state_q == ST_INIT) ? clr_cnt_q
                            : addr_q[`ICACHE_INDEX_LSB +: `ICACHE_INDEX_BITS];
    assign arr.lookup_tag   = tag_t'(addr_q[`ICACHE_TAG_LSB +: `ICACHE_TAG_BITS]);
    assign arr.fill_we      = fill_we;
    assign arr.valid_we     = (state_q == ST_INIT) ? '1 : fill_we;
    assign arr.valid_wdata  = (state_q != ST_INIT);
    assign arr.fifo_advance = (state_q == ST_FINISH);

    // ========================================
    // Fetch and memory ports
    // ========================================

    assign p_ready_o = ((state_q == ST_COMPARE) && arr.hit) || refill;

    // Request goes out the cycle after a miss is seen
    always_ff @(posedge clk_i)
    begin
        if (rst_i)
            m_strobe_o <= 1'b0;
        else
            m_strobe_o <= (state_q == ST_COMPARE) && !arr.hit;
    end

    // Line-aligned, stays put until the next strobe
    assign m_addr_o = {addr_q[`ICACHE_XLEN-1:`ICACHE_INDEX_LSB], {`ICACHE_INDEX_LSB{1'b0}}};

    // A new fetch must not start while one is in progress
    a_strobe_in_idle: assert property (@(posedge clk_i) disable iff (rst_i)
        p_strobe_i |-> (state_q == ST_IDLE));

    a_mreq_single: assert property (@(posedge clk_i) disable iff (rst_i)
        m_strobe_o |=> !m_strobe_o);

endmodule

// ==== rtl/cache_array_if.sv ====
`include "icache_consts.svh"

interface cache_array_if;
    import icache_pkg::*;

    // Lookup and write address, shared by tags, valids and lines
    set_index_t                 set_idx;
    // Tag of the held fetch address, also the tag written on refill
    tag_t                       lookup_tag;
    // One-hot refill enable for the victim way
    logic [`ICACHE_WAYS-1:0]    fill_we;
    // Valid bit write enables and the value written
    logic [`ICACHE_WAYS-1:0]    valid_we;
    logic                       valid_wdata;
    // Bumps the FIFO counter of set_idx
    logic                       fifo_advance;

    // Lookup result; on a miss hit_way carries the FIFO victim
    logic                       hit;
    way_sel_t                   hit_way;

    modport ctrl (
        output set_idx, lookup_tag, fill_we, valid_we, valid_wdata, fifo_advance,
        input  hit, hit_way
    );

    modport tags (
        input  set_idx, lookup_tag, fill_we, valid_we, valid_wdata, fifo_advance,
        output hit, hit_way
    );

    modport data (
        input  set_idx, fill_we, hit_way
    );

endinterface

// ==== rtl/icache_pkg.sv ====
`include "icache_consts.svh"

package icache_pkg;

    // ========================================
    // Address field types
    // ========================================

    // Set index, addr[7:4]
    typedef logic [`ICACHE_INDEX_BITS-1:0] set_index_t;

    // Stored tag, addr[31:8]
    typedef logic [`ICACHE_TAG_BITS-1:0] tag_t;

    // Way number, used for both the hit way and the FIFO victim
    typedef logic [`ICACHE_WAY_BITS-1:0] way_sel_t;

    // ========================================
    // Cache line
    // ========================================

    // Flat view is what memory returns and what the data array stores
    // Word view is indexed by the word offset, words[0] sits at bits 31:0
    typedef union packed {
        logic [`ICACHE_LINE_BITS-1:0]                          flat;
        logic [`ICACHE_WORDS_PER_LINE-1:0][`ICACHE_XLEN-1:0]   words;
    } cache_line_u;

endpackage

// ==== rtl/icache_consts.svh ====
`ifndef ICACHE_CONSTS_SVH
`define ICACHE_CONSTS_SVH

// ========================================
// Cache geometry
// ========================================

// Fetch word and line widths
`define ICACHE_XLEN            32
`define ICACHE_LINE_BITS       128
`define ICACHE_WORDS_PER_LINE  4

// 4 ways x 16 sets x 16 bytes = 1 KiB
`define ICACHE_WAYS            4
`define ICACHE_SETS            16
`define ICACHE_WAY_BITS        2

// ========================================
// Address fields
// ========================================

// Word select is addr[3:2], set index addr[7:4], tag addr[31:8]
`define ICACHE_OFFSET_BITS     2
`define ICACHE_OFFSET_LSB      2
`define ICACHE_INDEX_BITS      4
`define ICACHE_INDEX_LSB       4
`define ICACHE_TAG_BITS        24
`define ICACHE_TAG_LSB         8

`endif
